// File: hdl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

module decode_stage (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    pipe_ctrl_if.decode_mp        ctrl,
    input  wire logic [`XLEN-1:0] if_instr_i,
    input  wire logic [`XLEN-1:0] if_pc_i,
    output rv32i_pkg::ctrl_t      ex_ctrl_o,
    output logic [`XLEN-1:0]      ex_a_o,
    output logic [`XLEN-1:0]      ex_b_o,
    output logic [`XLEN-1:0]      ex_imm_o,
    output logic [`XLEN-1:0]      ex_pc_o
);
    import rv32i_pkg::*;

    instr_u           instr;
    ctrl_t            dec_ctrl;
    alu_op_e          f3_op;
    logic             f3_ok;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] regs [`REG_COUNT];

    assign instr       = if_instr_i;
    assign ctrl.id_rs1 = instr.r.rs1;
    assign ctrl.id_rs2 = instr.r.rs2;

    //////////////////////////////////////////////////////////////////////
    // Decoder
    //////////////////////////////////////////////////////////////////////

    // Shared by register and immediate ALU forms
    always_comb begin
        f3_ok = 1'b1;
        case (instr.r.funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_ctrl    = '0;
        dec_ctrl.rd = instr.r.rd;
        imm         = '0;
        case (instr.r.opcode)
            OPC_OP: begin
                dec_ctrl.reg_write = f3_ok;
                dec_ctrl.alu_op    = f3_op;
                if (instr.r.funct3 == 3'b000 && instr.r.funct7[5]) begin
                    dec_ctrl.alu_op = ALU_SUB;
                end
            end
            OPC_OP_IMM: begin
                dec_ctrl.reg_write = f3_ok;
                dec_ctrl.alu_op    = f3_op;
                dec_ctrl.use_imm   = 1'b1;
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            OPC_LUI: begin
                dec_ctrl.reg_write = 1'b1;
                dec_ctrl.alu_op    = ALU_PASS_B;
                dec_ctrl.use_imm   = 1'b1;
                imm = {instr.u.imm_31_12, 12'b0};
            end
            OPC_LOAD: begin
                // Word loads only
                dec_ctrl.reg_write = (instr.i.funct3 == 3'b010);
                dec_ctrl.mem_read  = (instr.i.funct3 == 3'b010);
                dec_ctrl.use_imm   = 1'b1;
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            end
            OPC_STORE: begin
                dec_ctrl.mem_write = (instr.s.funct3 == 3'b010);
                dec_ctrl.use_imm   = 1'b1;
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            OPC_BRANCH: begin
                dec_ctrl.is_branch = (instr.b.funct3[2:1] == 2'b00);
                dec_ctrl.branch_ne = instr.b.funct3[0];
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            OPC_JAL: begin
                dec_ctrl.reg_write = 1'b1;
                dec_ctrl.is_jal    = 1'b1;
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: begin
                dec_ctrl = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (ctrl.wb_we && ctrl.wb_rd != '0) begin
            regs[ctrl.wb_rd] <= ctrl.wb_data;
        end
    end

    // Same-cycle writeback bypasses the array
    always_comb begin
        rs1_data = regs[instr.r.rs1];
        rs2_data = regs[instr.r.rs2];
        if (ctrl.wb_we && ctrl.wb_rd != '0) begin
            if (ctrl.wb_rd == instr.r.rs1) begin
                rs1_data = ctrl.wb_data;
            end
            if (ctrl.wb_rd == instr.r.rs2) begin
                rs2_data = ctrl.wb_data;
            end
        end
    end

    // ID/EX
    always_ff @(posedge clk) begin
        if (!rst_n_i || ctrl.stall || ctrl.flush) begin
            ex_ctrl_o <= '0;
        end else begin
            ex_ctrl_o <= dec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_a_o   <= rs1_data;
        ex_b_o   <= rs2_data;
        ex_imm_o <= imm;
        ex_pc_o  <= if_pc_i;
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

module execute_stage (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    pipe_ctrl_if.execute_mp       ctrl,
    input  wire rv32i_pkg::ctrl_t ex_ctrl_i,
    input  wire logic [`XLEN-1:0] ex_a_i,
    input  wire logic [`XLEN-1:0] ex_b_i,
    input  wire logic [`XLEN-1:0] ex_imm_i,
    input  wire logic [`XLEN-1:0] ex_pc_i,
    output rv32i_pkg::ctrl_t      mem_ctrl_o,
    output logic [`XLEN-1:0]      mem_result_o,
    output logic [`XLEN-1:0]      mem_store_o
);
    import rv32i_pkg::*;

    reg_addr_t        rs1_q;
    reg_addr_t        rs2_q;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic             branch_taken;

    // Source numbers follow their instruction into execute
    always_ff @(posedge clk) begin
        rs1_q <= ctrl.id_rs1;
        rs2_q <= ctrl.id_rs2;
    end

    assign ctrl.ex_rs1     = rs1_q;
    assign ctrl.ex_rs2     = rs2_q;
    assign ctrl.ex_rd      = ex_ctrl_i.rd;
    assign ctrl.ex_is_load = ex_ctrl_i.mem_read;

    // Memory stage has priority, it holds the younger result
    assign op_a  = ctrl.fwd_a_sel[1] ? ctrl.mem_result :
                   ctrl.fwd_a_sel[0] ? ctrl.wb_data : ex_a_i;
    assign fwd_b = ctrl.fwd_b_sel[1] ? ctrl.mem_result :
                   ctrl.fwd_b_sel[0] ? ctrl.wb_data : ex_b_i;
    assign op_b  = ex_ctrl_i.use_imm ? ex_imm_i : fwd_b;

    always_comb begin
        case (ex_ctrl_i.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////////////////////////

    assign branch_taken     = ex_ctrl_i.is_branch &&
                              ((op_a == fwd_b) != ex_ctrl_i.branch_ne);
    assign ctrl.redirect    = branch_taken || ex_ctrl_i.is_jal;
    assign ctrl.redirect_pc = ex_pc_i + ex_imm_i;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_ctrl_o <= '0;
        end else begin
            mem_ctrl_o <= ex_ctrl_i;
        end
    end

    always_ff @(posedge clk) begin
        // JAL links the return address
        mem_result_o <= ex_ctrl_i.is_jal ? ex_pc_i + 'd4 : alu_out;
        mem_store_o  <= fwd_b;
    end

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

module fetch_stage (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    pipe_ctrl_if.fetch_mp         ctrl,
    input  wire logic [`XLEN-1:0] instr_i,
    output logic [`XLEN-1:0]      instr_addr_o,
    output logic [`XLEN-1:0]      if_instr_o,
    output logic [`XLEN-1:0]      if_pc_o
);

    // ADDI x0, x0, 0
    localparam logic [`XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    logic [`XLEN-1:0] pc;

    assign instr_addr_o = pc;

    // Static not-taken prediction
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc <= `RESET_PC;
        end else if (ctrl.flush) begin
            pc <= ctrl.redirect_pc;
        end else if (!ctrl.stall) begin
            pc <= pc + 'd4;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // IF/ID
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i || ctrl.flush) begin
            if_instr_o <= NOP_INSTR;
        end else if (!ctrl.stall) begin
            if_instr_o <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.stall) begin
            if_pc_o <= pc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    pipe_ctrl_if.hazard_mp ctrl
);
    import rv32i_pkg::*;

    // Returns {from memory, from writeback}
    function automatic logic [1:0] fwd_sel(
        input reg_addr_t rs,
        input reg_addr_t mem_rd,
        input logic      mem_we,
        input reg_addr_t wb_rd,
        input logic      wb_we
    );
        logic mem_hit;
        logic wb_hit;
        mem_hit = mem_we && mem_rd != '0 && mem_rd == rs;
        wb_hit  = wb_we && wb_rd != '0 && wb_rd == rs;
        return {mem_hit, wb_hit && !mem_hit};
    endfunction

    assign ctrl.fwd_a_sel = fwd_sel(ctrl.ex_rs1, ctrl.mem_rd, ctrl.mem_we,
                                    ctrl.wb_rd, ctrl.wb_we);
    assign ctrl.fwd_b_sel = fwd_sel(ctrl.ex_rs2, ctrl.mem_rd, ctrl.mem_we,
                                    ctrl.wb_rd, ctrl.wb_we);

    // Load result is not ready until writeback, so hold decode one cycle
    assign ctrl.stall = ctrl.ex_is_load && ctrl.ex_rd != '0 &&
                        (ctrl.ex_rd == ctrl.id_rs1 || ctrl.ex_rd == ctrl.id_rs2);

    // Taken branch or jump kills IF/ID and ID/EX
    assign ctrl.flush = ctrl.redirect;

endmodule

`default_nettype wire

// File: hdl/mem_wb_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

module mem_wb_stage (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    pipe_ctrl_if.memwb_mp         ctrl,
    input  wire rv32i_pkg::ctrl_t mem_ctrl_i,
    input  wire logic [`XLEN-1:0] mem_result_i,
    input  wire logic [`XLEN-1:0] mem_store_i,
    input  wire logic [`XLEN-1:0] load_data_i,
    output logic [`XLEN-1:0]      mem_addr_o,
    output logic [`XLEN-1:0]      store_data_o,
    output logic                  mem_we_o
);
    import rv32i_pkg::*;

    ctrl_t            wb_ctrl;
    logic [`XLEN-1:0] wb_load;
    logic [`XLEN-1:0] wb_alu;

    // Data memory, whole words only
    assign mem_addr_o   = mem_result_i;
    assign store_data_o = mem_store_i;
    assign mem_we_o     = mem_ctrl_i.mem_write;

    assign ctrl.mem_rd     = mem_ctrl_i.rd;
    assign ctrl.mem_we     = mem_ctrl_i.reg_write;
    assign ctrl.mem_result = mem_result_i;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_ctrl <= '0;
        end else begin
            wb_ctrl <= mem_ctrl_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_load <= load_data_i;
        wb_alu  <= mem_result_i;
    end

    assign ctrl.wb_rd   = wb_ctrl.rd;
    assign ctrl.wb_we   = wb_ctrl.reg_write;
    assign ctrl.wb_data = wb_ctrl.mem_read ? wb_load : wb_alu;

endmodule

`default_nettype wire

// File: hdl/pipe_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

interface pipe_ctrl_if;
    import rv32i_pkg::*;

    // Sources in decode and execute
    reg_addr_t        id_rs1;
    reg_addr_t        id_rs2;
    reg_addr_t        ex_rs1;
    reg_addr_t        ex_rs2;
    reg_addr_t        ex_rd;
    logic             ex_is_load;

    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;

    // Results still in flight
    reg_addr_t        mem_rd;
    logic             mem_we;
    logic [`XLEN-1:0] mem_result;
    reg_addr_t        wb_rd;
    logic             wb_we;
    logic [`XLEN-1:0] wb_data;

    logic             stall;
    logic             flush;
    // Bit 1 takes the memory stage, bit 0 the writeback stage
    logic [1:0]       fwd_a_sel;
    logic [1:0]       fwd_b_sel;

    modport fetch_mp (
        input stall, flush, redirect_pc
    );

    modport decode_mp (
        output id_rs1, id_rs2,
        input  stall, flush, wb_rd, wb_we, wb_data
    );

    modport execute_mp (
        output ex_rs1, ex_rs2, ex_rd, ex_is_load, redirect, redirect_pc,
        input  id_rs1, id_rs2, fwd_a_sel, fwd_b_sel, mem_result, wb_data
    );

    modport memwb_mp (
        output mem_rd, mem_we, mem_result, wb_rd, wb_we, wb_data
    );

    modport hazard_mp (
        input  id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, ex_is_load, redirect,
        input  mem_rd, mem_we, wb_rd, wb_we,
        output stall, flush, fwd_a_sel, fwd_b_sel
    );

endinterface

`default_nettype wire

// File: hdl/rv32i_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

module rv32i_core (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    input  wire logic [`XLEN-1:0] instr_i,
    output logic [`XLEN-1:0]      instr_addr_o,
    input  wire logic [`XLEN-1:0] load_data_i,
    output logic [`XLEN-1:0]      mem_addr_o,
    output logic [`XLEN-1:0]      store_data_o,
    output logic                  mem_we_o
);
    import rv32i_pkg::*;

    logic [`XLEN-1:0] if_instr;
    logic [`XLEN-1:0] if_pc;

    ctrl_t            ex_ctrl;
    logic [`XLEN-1:0] ex_a;
    logic [`XLEN-1:0] ex_b;
    logic [`XLEN-1:0] ex_imm;
    logic [`XLEN-1:0] ex_pc;

    ctrl_t            mem_ctrl;
    logic [`XLEN-1:0] mem_result;
    logic [`XLEN-1:0] mem_store;

    pipe_ctrl_if pipe_ctrl ();

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ctrl         (pipe_ctrl.fetch_mp),
        .instr_i      (instr_i),
        .instr_addr_o (instr_addr_o),
        .if_instr_o   (if_instr),
        .if_pc_o      (if_pc)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ctrl       (pipe_ctrl.decode_mp),
        .if_instr_i (if_instr),
        .if_pc_i    (if_pc),
        .ex_ctrl_o  (ex_ctrl),
        .ex_a_o     (ex_a),
        .ex_b_o     (ex_b),
        .ex_imm_o   (ex_imm),
        .ex_pc_o    (ex_pc)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ctrl         (pipe_ctrl.execute_mp),
        .ex_ctrl_i    (ex_ctrl),
        .ex_a_i       (ex_a),
        .ex_b_i       (ex_b),
        .ex_imm_i     (ex_imm),
        .ex_pc_i      (ex_pc),
        .mem_ctrl_o   (mem_ctrl),
        .mem_result_o (mem_result),
        .mem_store_o  (mem_store)
    );

    mem_wb_stage u_mem_wb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ctrl         (pipe_ctrl.memwb_mp),
        .mem_ctrl_i   (mem_ctrl),
        .mem_result_i (mem_result),
        .mem_store_i  (mem_store),
        .load_data_i  (load_data_i),
        .mem_addr_o   (mem_addr_o),
        .store_data_o (store_data_o),
        .mem_we_o     (mem_we_o)
    );

    // Hazard control
    hazard_unit u_hazard (
        .ctrl (pipe_ctrl.hazard_mp)
    );

endmodule

`default_nettype wire

// File: hdl/rv32i_defs.svh
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// Data and address width
`define XLEN 32

// Architectural integer registers
`define REG_COUNT 32

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: hdl/rv32i_pkg.sv
`default_nettype none
`include "rv32i_defs.svh"

package rv32i_pkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

    // Major opcodes, anything else decodes as a no-op
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    // One fetched word, seen through each format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

    // All zero is a bubble
    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        reg_addr_t rd;
    } ctrl_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/rv32i_pkg.sv
hdl/pipe_ctrl_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/hazard_unit.sv
hdl/rv32i_core.sv
verification/tb_mem_model.sv
verification/rv32i_core_tb.sv

// File: verification/rv32i_core_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

module rv32i_core_tb;

    localparam int               RESET_CYCLES     = 10;
    localparam int               CYCLES_PER_INSTR = 8;
    localparam int               DRAIN_CYCLES     = 5;
    localparam logic [`XLEN-1:0] LOAD_BASE        = 32'h0000_0200;
    localparam logic [`XLEN-1:0] STORE_BASE       = 32'h0000_0300;

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] instr_addr;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] store_data;
    logic             mem_we;

    // Program words and the stores it must produce
    logic [`XLEN-1:0] prog_q [$];
    string            exp_name [$];
    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];

    int value_errors = 0;
    int other_errors = 0;
    bit prog_ready   = 1'b0;

    rv32i_core UUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .instr_i      (instr),
        .instr_addr_o (instr_addr),
        .load_data_i  (load_data),
        .mem_addr_o   (mem_addr),
        .store_data_o (store_data),
        .mem_we_o     (mem_we)
    );

    tb_mem_model mem_model (
        .clk          (clk),
        .instr_addr_i (instr_addr),
        .instr_o      (instr),
        .data_addr_i  (mem_addr),
        .store_data_i (store_data),
        .we_i         (mem_we),
        .load_data_o  (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_instr(input logic [31:0] word);
        prog_q.push_back(word);
    endtask

    // SW rs2 to STORE_BASE + offset through x10
    task automatic store_and_expect(input string name, input logic [11:0] offset,
                                    input logic [4:0] rs2, input logic [`XLEN-1:0] value);
        add_instr(stype(offset, rs2, 5'd10));
        exp_name.push_back(name);
        exp_addr.push_back(STORE_BASE + offset);
        exp_data.push_back(value);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program and expected stores
    //////////////////////////////////////////////////////////////////////

    task automatic build_program(input logic [`XLEN-1:0] ld0, input logic [`XLEN-1:0] ld1);
        logic [`XLEN-1:0] x1;
        logic [`XLEN-1:0] x2;
        logic [`XLEN-1:0] x3;
        logic [`XLEN-1:0] x4;
        logic [`XLEN-1:0] x7;
        logic [`XLEN-1:0] x8;
        logic [`XLEN-1:0] x19;
        logic [`XLEN-1:0] jal_pc;
        x1  = 32'h1234_5000 + 32'h0000_0678;
        x2  = 32'd0 - 32'd5;
        x3  = x1 - x2;
        x4  = ($signed(x2) < $signed(x3)) ? 32'd1 : 32'd0;
        x7  = ((x3 ^ x1) | x4) & 32'h0000_00FF;
        x8  = ($signed(x2) < -32'sd4) ? 32'd1 : 32'd0;
        x19 = ~(x7 | 32'h0000_0700) & x1;

        add_instr(itype(12'h300, 5'd0, 3'b000, 5'd10, OPC_IMM));
        add_instr(itype(12'h200, 5'd0, 3'b000, 5'd11, OPC_IMM));

        // Back-to-back dependent chain
        add_instr(utype(20'h12345, 5'd1, OPC_LUI));
        add_instr(itype(12'h678, 5'd1, 3'b000, 5'd1, OPC_IMM));
        add_instr(itype(12'hFFB, 5'd0, 3'b000, 5'd2, OPC_IMM));
        add_instr(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
        add_instr(rtype(7'h00, 5'd3, 5'd2, 3'b010, 5'd4));
        add_instr(rtype(7'h00, 5'd1, 5'd3, 3'b100, 5'd5));
        add_instr(rtype(7'h00, 5'd4, 5'd5, 3'b110, 5'd6));
        add_instr(itype(12'h0FF, 5'd6, 3'b111, 5'd7, OPC_IMM));
        add_instr(itype(12'hFFC, 5'd2, 3'b010, 5'd8, OPC_IMM));
        add_instr(itype(12'h700, 5'd7, 3'b110, 5'd9, OPC_IMM));
        add_instr(itype(12'hFFF, 5'd9, 3'b100, 5'd9, OPC_IMM));
        add_instr(rtype(7'h00, 5'd1, 5'd9, 3'b111, 5'd19));
        store_and_expect("xori_and", 12'd20, 5'd19, x19);
        store_and_expect("lui_addi", 12'd0, 5'd1, x1);
        store_and_expect("sub_fwd", 12'd4, 5'd3, x3);
        store_and_expect("slt", 12'd8, 5'd4, x4);
        store_and_expect("andi_chain", 12'd12, 5'd7, x7);
        store_and_expect("slti_neg", 12'd16, 5'd8, x8);

        // Load-use
        add_instr(itype(12'h000, 5'd11, 3'b010, 5'd12, OPC_LOAD));
        add_instr(rtype(7'h00, 5'd1, 5'd12, 3'b000, 5'd13));
        store_and_expect("load_use_add", 12'd24, 5'd13, ld0 + x1);
        add_instr(itype(12'h004, 5'd11, 3'b010, 5'd14, OPC_LOAD));
        store_and_expect("load_use_store", 12'd28, 5'd14, ld1);

        // Taken branches skip two shadow stores each
        add_instr(itype(12'd7, 5'd0, 3'b000, 5'd15, OPC_IMM));
        add_instr(itype(12'd7, 5'd0, 3'b000, 5'd16, OPC_IMM));
        add_instr(btype(13'd12, 5'd16, 5'd15, 3'b000));
        add_instr(stype(12'd32, 5'd1, 5'd10));
        add_instr(stype(12'd36, 5'd1, 5'd10));
        add_instr(btype(13'd12, 5'd1, 5'd15, 3'b001));
        add_instr(stype(12'd32, 5'd2, 5'd10));
        add_instr(stype(12'd36, 5'd2, 5'd10));
        add_instr(btype(13'd8, 5'd1, 5'd15, 3'b000));
        store_and_expect("beq_not_taken", 12'd32, 5'd15, 32'd7);
        add_instr(btype(13'd8, 5'd16, 5'd15, 3'b001));
        store_and_expect("bne_not_taken", 12'd36, 5'd3, x3);

        jal_pc = prog_q.size() * 4;
        add_instr(jtype(21'd12, 5'd17));
        add_instr(stype(12'd40, 5'd1, 5'd10));
        add_instr(stype(12'd44, 5'd1, 5'd10));
        store_and_expect("jal_link", 12'd40, 5'd17, jal_pc + 32'd4);

        // Writes to x0 are dropped
        add_instr(itype(12'd123, 5'd0, 3'b000, 5'd0, OPC_IMM));
        store_and_expect("x0_addi", 12'd44, 5'd0, 32'd0);
        add_instr(utype(20'hABCDE, 5'd0, OPC_LUI));
        add_instr(rtype(7'h00, 5'd1, 5'd0, 3'b000, 5'd18));
        store_and_expect("x0_lui_read", 12'd48, 5'd18, x1);
        add_instr(jtype(21'd8, 5'd0));
        add_instr(stype(12'd52, 5'd1, 5'd10));
        store_and_expect("jal_x0", 12'd52, 5'd0, 32'd0);

        // AUIPC is not supported and leaves x1 alone
        add_instr(utype(20'h00001, 5'd1, OPC_AUIPC));
        store_and_expect("unsupported_nop", 12'd56, 5'd1, x1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking and summary
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_stores();
        int logged;
        int wanted;
        logged = mem_model.store_data_q.size();
        wanted = exp_data.size();
        for (int i = 0; i < logged && i < wanted; i++) begin
            check_value($sformatf("%s address", exp_name[i]), exp_addr[i],
                        mem_model.store_addr_q[i]);
            check_value(exp_name[i], exp_data[i], mem_model.store_data_q[i]);
        end
        if (logged < wanted) begin
            other_errors++;
            $display("Missing stores: %0d expected but only %0d seen", wanted, logged);
        end else if (logged > wanted) begin
            other_errors++;
            $display("Extra stores: %0d expected but %0d seen", wanted, logged);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        logic [`XLEN-1:0] ld0;
        logic [`XLEN-1:0] ld1;
        int               end_addr;
        rst_n = 1'b0;
        void'($urandom(35813));
        @(posedge clk);
        @(negedge clk);
        ld0 = $urandom();
        ld1 = $urandom();
        mem_model.ram[LOAD_BASE >> 2]         = ld0;
        mem_model.ram[(LOAD_BASE >> 2) + 1] = ld1;
        build_program(ld0, ld1);
        foreach (prog_q[i]) begin
            mem_model.rom[i] = prog_q[i];
        end
        prog_ready = 1'b1;

        // Reset state holds through reset and at its release
        repeat (RESET_CYCLES - 1) begin
            check_value("reset_mem_we", 32'd0, {31'd0, mem_we});
            check_value("reset_pc", `RESET_PC, instr_addr);
            @(negedge clk);
        end
        rst_n = 1'b1;
        check_value("release_mem_we", 32'd0, {31'd0, mem_we});
        check_value("release_pc", `RESET_PC, instr_addr);

        end_addr = prog_q.size() * 4;
        while (instr_addr < end_addr) begin
            @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        compare_stores();
        finish_run();
    end

    // Watchdog
    initial begin
        wait (prog_ready);
        repeat (RESET_CYCLES + prog_q.size() * CYCLES_PER_INSTR) @(posedge clk);
        other_errors++;
        $display("Timeout: program did not reach its end address in time");
        finish_run();
    end

endmodule

`default_nettype wire

// File: verification/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none
`include "rv32i_defs.svh"

module tb_mem_model #(
    parameter int ROM_WORDS = 128,
    parameter int RAM_WORDS = 256
) (
    input  wire logic             clk,
    input  wire logic [`XLEN-1:0] instr_addr_i,
    output logic [`XLEN-1:0]      instr_o,
    input  wire logic [`XLEN-1:0] data_addr_i,
    input  wire logic [`XLEN-1:0] store_data_i,
    input  wire logic             we_i,
    output logic [`XLEN-1:0]      load_data_o
);

    localparam int               RAM_AW   = $clog2(RAM_WORDS);
    localparam logic [`XLEN-1:0] NOP_WORD = 32'h0000_0013;

    logic [`XLEN-1:0] rom [ROM_WORDS];
    logic [`XLEN-1:0] ram [RAM_WORDS];

    // Every committed store, in order
    logic [`XLEN-1:0] store_addr_q [$];
    logic [`XLEN-1:0] store_data_q [$];

    initial begin
        logic [`XLEN-1:0] addr;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = NOP_WORD;
        end
        // Fill word carries its own byte address
        for (int i = 0; i < RAM_WORDS; i++) begin
            addr   = i * 4;
            ram[i] = {~addr[15:0], addr[15:0]};
        end
    end

    // Past the end of the program only NOPs are fetched
    assign instr_o = (instr_addr_i[`XLEN-1:2] < ROM_WORDS) ?
                     rom[instr_addr_i[`XLEN-1:2]] : NOP_WORD;

    assign load_data_o = ram[data_addr_i[RAM_AW+1:2]];

    always @(posedge clk) begin
        if (we_i === 1'b1) begin
            ram[data_addr_i[RAM_AW+1:2]] <= store_data_i;
            store_addr_q.push_back(data_addr_i);
            store_data_q.push_back(store_data_i);
        end
    end

endmodule

`default_nettype wire
